/* tb.f */
+incdir+verification
hw/piece_pkg.sv
hw/move_pkg.sv
hw/spawn_table.sv
hw/shift_unit.sv
hw/rotate_unit.sv
hw/move_control.sv
hw/piece_register.sv
hw/piece_mover.sv
verification/tb_piece_mover.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f tb.f --top-module tb_piece_mover -o sim_piece_mover

# the simulator exits non-zero on a failure, so the log decides
./obj_dir/sim_piece_mover > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

/* verification/piece_model.svh */
`ifndef PIECE_MODEL_SVH
`define PIECE_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// spawn table with x packed as nibbles and y as a row 1 mask
//////////////////////////////////////////////////////////////////////

function automatic coord_x_t spawn_x(input logic [2:0] kind, input int idx);
    logic [15:0] row;
    case (kind)
        3'd1: row = 16'h3456;  // line
        3'd2: row = 16'h4545;  // square
        3'd3: row = 16'h4345;
        3'd4: row = 16'h5645;
        3'd5: row = 16'h4556;
        3'd6: row = 16'h6456;
        3'd7: row = 16'h3345;
        default: row = 16'h0000;
    endcase
    spawn_x = row[(4-idx)*4 +: 4];
endfunction

function automatic coord_y_t spawn_y(input logic [2:0] kind, input int idx);
    logic [3:0] lower;  // cells sitting on row 1
    case (kind)
        3'd2, 3'd4, 3'd5: lower = 4'b0011;
        3'd3, 3'd6, 3'd7: lower = 4'b0111;
        default: lower = 4'b0000;
    endcase
    spawn_y = coord_y_t'(lower[4-idx]);
endfunction

// codes 011 and 100 move sideways and 010 moves down
function automatic coord_x_t shift_x(input coord_x_t x, input logic [2:0] code);
    case (code)
        3'b011:  shift_x = coord_x_t'(int'(x) - 1);
        3'b100:  shift_x = coord_x_t'(int'(x) + 1);
        default: shift_x = x;
    endcase
endfunction

function automatic coord_y_t shift_y(input coord_y_t y, input logic [2:0] code);
    shift_y = (code == 3'b010) ? coord_y_t'(int'(y) + 1) : y;
endfunction

function automatic coord_x_t rot_x(input coord_x_t px, input coord_y_t py,
                                   input coord_y_t y, input logic cw);
    coord_y_t diff;
    int       dy;
    diff  = y - py;
    dy    = int'($signed(diff));
    rot_x = cw ? coord_x_t'(int'(px) - dy) : coord_x_t'(int'(px) + dy);
endfunction

function automatic coord_y_t rot_y(input coord_x_t px, input coord_y_t py,
                                   input coord_x_t x, input logic cw);
    coord_x_t diff;
    int       dx;
    diff  = x - px;
    dx    = int'($signed(diff));
    rot_y = cw ? coord_y_t'(int'(py) + dx) : coord_y_t'(int'(py) - dx);
endfunction

`endif

/* verification/tb_piece_mover.sv */
`timescale 1ns/10ps

module tb_piece_mover import piece_pkg::*; import move_pkg::*; ();

    localparam int clk_period   = 10;
    localparam int episodes     = 64;
    localparam int reset_cycles = 2;
    localparam int moves        = 40;
    localparam int timeout_ns   = 2 * episodes * (reset_cycles + moves) * clk_period;
    localparam logic [31:0] lfsr_seed = 32'd75437;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic        clk;
    logic        reset;
    movement_t   movement;
    block_kind_t block_type;
    coord_x_t    x1, x2, x3, x4;
    coord_y_t    y1, y2, y3, y4;

    logic [31:0] lfsr_state;
    coord_x_t    mx [1:4];  // model cells
    coord_y_t    my [1:4];
    logic        pend_reset;  // what the next edge samples
    logic [2:0]  pend_kind;
    logic [2:0]  pend_code;
    string       pend_tag;

    `include "piece_model.svh"

    piece_mover piece_mover_inst (
        .clk(clk), .reset(reset), .movement(movement), .block_type(block_type),
        .x1(x1), .x2(x2), .x3(x3), .x4(x4),
        .y1(y1), .y2(y2), .y3(y3), .y4(y4)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("run timed out after %0d ns without reaching the end", timeout_ns);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic apply_model(input logic r, input logic [2:0] kind, input logic [2:0] code);
        coord_x_t nx [1:4];
        coord_y_t ny [1:4];
        for (int c = 1; c <= 4; c++) begin
            nx[c] = mx[c];
            ny[c] = my[c];
            if (r) begin
                nx[c] = spawn_x(kind, c);
                ny[c] = spawn_y(kind, c);
            end else if (code <= 3'b001 && kind != 3'd2) begin  // square never turns
                nx[c] = rot_x(mx[3], my[3], my[c], code == 3'b000);
                ny[c] = rot_y(mx[3], my[3], mx[c], code == 3'b000);
            end else if (code >= 3'b010 && code <= 3'b100) begin
                nx[c] = shift_x(mx[c], code);
                ny[c] = shift_y(my[c], code);
            end
        end
        mx = nx;
        my = ny;
    endtask

    task automatic check_cells(input string tag);
        check_value({tag, " x1"}, int'(mx[1]), int'(x1));
        check_value({tag, " x2"}, int'(mx[2]), int'(x2));
        check_value({tag, " x3"}, int'(mx[3]), int'(x3));
        check_value({tag, " x4"}, int'(mx[4]), int'(x4));
        check_value({tag, " y1"}, int'(my[1]), int'(y1));
        check_value({tag, " y2"}, int'(my[2]), int'(y2));
        check_value({tag, " y3"}, int'(my[3]), int'(y3));
        check_value({tag, " y4"}, int'(my[4]), int'(y4));
    endtask

    // drive for the next edge, check the result of the last one at the falling edge
    task automatic step(input logic r, input logic [2:0] kind, input logic [2:0] code,
                        input string tag);
        string label;
        @(posedge clk);
        apply_model(pend_reset, pend_kind, pend_code);
        label = pend_tag;
        reset      <= r;
        block_type <= block_kind_t'(kind);
        movement   <= movement_t'(code);
        pend_reset = r;
        pend_kind  = kind;
        pend_code  = code;
        pend_tag   = $sformatf("%s code %b", tag, code);
        @(negedge clk);
        check_cells(label);
    endtask

    //////////////////////////////////////////////////////////////////////
    // episodes
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        logic [2:0]  kind;
        reset      = 1'b1;
        movement   = idle;
        block_type = none;
        lfsr_state = lfsr_seed;
        pend_reset = 1'b1;
        pend_kind  = 3'd0;
        pend_code  = 3'b101;
        pend_tag   = "startup spawn";
        kind       = 3'd0;
        for (int ep = 0; ep < episodes; ep++) begin
            draw_bits(3, rnd);
            kind = rnd[2:0];
            for (int i = 0; i < reset_cycles; i++) begin
                draw_bits(3, rnd);  // movement ignored under reset
                step(1'b1, kind, rnd[2:0], $sformatf("ep %0d reset %0d", ep, i));
            end
            for (int i = 0; i < moves; i++) begin
                draw_bits(3, rnd);
                step(1'b0, kind, rnd[2:0], $sformatf("ep %0d move %0d", ep, i));
            end
        end
        step(1'b0, kind, 3'b101, "final");  // flushes the last move
        $display(">>> PASS");
        $finish;
    end

endmodule

/* hw/piece_mover.sv */
`timescale 1ns/10ps

module piece_mover import piece_pkg::*; import move_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  movement_t   movement,
    input  block_kind_t block_type,
    output coord_x_t    x1, x2, x3, x4,
    output coord_y_t    y1, y2, y3, y4
);

    move_cmd_t cmd;

    // candidate cell sets
    coord_x_t spawn_x1, spawn_x2, spawn_x3, spawn_x4;
    coord_y_t spawn_y1, spawn_y2, spawn_y3, spawn_y4;
    coord_x_t shift_x1, shift_x2, shift_x3, shift_x4;
    coord_y_t shift_y1, shift_y2, shift_y3, shift_y4;
    coord_x_t rot_x1, rot_x2, rot_x3, rot_x4;
    coord_y_t rot_y1, rot_y2, rot_y3, rot_y4;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    move_control move_control_inst (
        .*
    );

    spawn_table spawn_table_inst (
        .*
    );

    //////////////////////////////////////////////////////////////////////
    // next position candidates
    //////////////////////////////////////////////////////////////////////

    shift_unit shift_unit_inst (
        .*
    );

    rotate_unit rotate_unit_inst (
        .*
    );

    //////////////////////////////////////////////////////////////////////
    // state
    //////////////////////////////////////////////////////////////////////

    piece_register piece_register_inst (
        .*
    );

endmodule

/* hw/piece_register.sv */
`timescale 1ns/10ps

module piece_register import piece_pkg::*; import move_pkg::*; (
    input  logic      clk,
    input  move_cmd_t cmd,
    input  coord_x_t  spawn_x1, spawn_x2, spawn_x3, spawn_x4,
    input  coord_y_t  spawn_y1, spawn_y2, spawn_y3, spawn_y4,
    input  coord_x_t  shift_x1, shift_x2, shift_x3, shift_x4,
    input  coord_y_t  shift_y1, shift_y2, shift_y3, shift_y4,
    input  coord_x_t  rot_x1, rot_x2, rot_x3, rot_x4,
    input  coord_y_t  rot_y1, rot_y2, rot_y3, rot_y4,
    output coord_x_t  x1, x2, x3, x4,
    output coord_y_t  y1, y2, y3, y4
);

    logic [4*grid_x_bits-1:0] next_x;
    logic [4*grid_y_bits-1:0] next_y;

    // pick the candidate set for this cycle
    always_comb begin
        case (cmd)
            cmd_spawn: begin
                next_x = {spawn_x1, spawn_x2, spawn_x3, spawn_x4};
                next_y = {spawn_y1, spawn_y2, spawn_y3, spawn_y4};
            end
            cmd_down, cmd_left, cmd_right: begin
                next_x = {shift_x1, shift_x2, shift_x3, shift_x4};
                next_y = {shift_y1, shift_y2, shift_y3, shift_y4};
            end
            cmd_rot_cw, cmd_rot_ccw: begin
                next_x = {rot_x1, rot_x2, rot_x3, rot_x4};
                next_y = {rot_y1, rot_y2, rot_y3, rot_y4};
            end
            default: begin
                // hold
                next_x = {x1, x2, x3, x4};
                next_y = {y1, y2, y3, y4};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        {x1, x2, x3, x4} <= next_x;
        {y1, y2, y3, y4} <= next_y;
    end

endmodule

/* hw/move_control.sv */
`timescale 1ns/10ps

module move_control import piece_pkg::*; import move_pkg::*; (
    input  logic        reset,
    input  movement_t   movement,
    input  block_kind_t block_type,
    output move_cmd_t   cmd
);

    logic no_spin;

    assign no_spin = (block_type == square);  // square looks the same turned

    always_comb begin
        if (reset) begin
            cmd = cmd_spawn;  // reload while reset is held
        end else begin
            case (movement)
                rot_cw: begin
                    cmd = no_spin ? cmd_hold : cmd_rot_cw;
                end
                rot_ccw: begin
                    cmd = no_spin ? cmd_hold : cmd_rot_ccw;
                end
                down:    cmd = cmd_down;
                left:    cmd = cmd_left;
                right:   cmd = cmd_right;
                idle:    cmd = cmd_hold;
                default: cmd = cmd_hold;  // 110 and 111
            endcase
        end
    end

endmodule

/* hw/rotate_unit.sv */
`timescale 1ns/10ps

module rotate_unit import piece_pkg::*; import move_pkg::*; (
    input  move_cmd_t cmd,
    input  coord_x_t  x1, x2, x3, x4,
    input  coord_y_t  y1, y2, y3, y4,
    output coord_x_t  rot_x1, rot_x2, rot_x3, rot_x4,
    output coord_y_t  rot_y1, rot_y2, rot_y3, rot_y4
);

    typedef logic signed [grid_x_bits-1:0] off_x_t;
    typedef logic signed [grid_y_bits-1:0] off_y_t;

    logic     cw;
    coord_x_t px;
    coord_y_t py;

    assign cw = (cmd == cmd_rot_cw);  // anything else turns the other way
    assign px = x3;                   // pivot is cell 3
    assign py = y3;

    // new column comes from the row offset
    function automatic coord_x_t turn_x(coord_x_t cx, coord_y_t cy, coord_y_t y, logic clockwise);
        coord_x_t dy_cut;
        dy_cut = coord_x_t'(y - cy);  // low bits of the signed row offset
        turn_x = clockwise ? cx - dy_cut : cx + dy_cut;
    endfunction

    // new row comes from the column offset
    function automatic coord_y_t turn_y(coord_x_t cx, coord_y_t cy, coord_x_t x, logic clockwise);
        off_x_t   dx;
        coord_y_t dx_wide;
        dx      = off_x_t'(x - cx);
        dx_wide = coord_y_t'(off_y_t'(dx));  // sign extend to row width
        turn_y  = clockwise ? cy + dx_wide : cy - dx_wide;
    endfunction

    assign rot_x1 = turn_x(px, py, y1, cw);
    assign rot_x2 = turn_x(px, py, y2, cw);
    assign rot_x3 = turn_x(px, py, y3, cw);
    assign rot_x4 = turn_x(px, py, y4, cw);

    assign rot_y1 = turn_y(px, py, x1, cw);
    assign rot_y2 = turn_y(px, py, x2, cw);
    assign rot_y3 = turn_y(px, py, x3, cw);
    assign rot_y4 = turn_y(px, py, x4, cw);

endmodule

/* hw/shift_unit.sv */
`timescale 1ns/10ps

module shift_unit import piece_pkg::*; import move_pkg::*; (
    input  move_cmd_t cmd,
    input  coord_x_t  x1, x2, x3, x4,
    input  coord_y_t  y1, y2, y3, y4,
    output coord_x_t  shift_x1, shift_x2, shift_x3, shift_x4,
    output coord_y_t  shift_y1, shift_y2, shift_y3, shift_y4
);

    coord_x_t dx;
    coord_y_t dy;

    // one offset pair for the whole piece
    always_comb begin
        dx = '0;
        dy = '0;
        case (cmd)
            cmd_down:  dy = coord_y_t'(1);
            cmd_left:  dx = '1;  // minus one mod 16
            cmd_right: dx = coord_x_t'(1);
            default: ;
        endcase
    end

    // adds wrap at the coordinate width
    assign shift_x1 = x1 + dx;
    assign shift_x2 = x2 + dx;
    assign shift_x3 = x3 + dx;
    assign shift_x4 = x4 + dx;

    assign shift_y1 = y1 + dy;
    assign shift_y2 = y2 + dy;
    assign shift_y3 = y3 + dy;
    assign shift_y4 = y4 + dy;

endmodule

/* hw/spawn_table.sv */
`timescale 1ns/10ps

module spawn_table import piece_pkg::*; (
    input  block_kind_t block_type,
    output coord_x_t    spawn_x1, spawn_x2, spawn_x3, spawn_x4,
    output coord_y_t    spawn_y1, spawn_y2, spawn_y3, spawn_y4
);

    typedef logic [4*grid_x_bits-1:0] x_set_t;  // cells 1..4 with cell 1 in the msbs
    typedef logic [4*grid_y_bits-1:0] y_set_t;

    //////////////////////////////////////////////////////////////////////
    // spawn positions per kind
    //////////////////////////////////////////////////////////////////////

    localparam x_set_t line_x   = {4'd3, 4'd4, 4'd5, 4'd6};
    localparam y_set_t line_y   = {5'd0, 5'd0, 5'd0, 5'd0};
    localparam x_set_t square_x = {4'd4, 4'd5, 4'd4, 4'd5};
    localparam y_set_t square_y = {5'd0, 5'd0, 5'd1, 5'd1};
    localparam x_set_t tee_x    = {4'd4, 4'd3, 4'd4, 4'd5};
    localparam y_set_t tee_y    = {5'd0, 5'd1, 5'd1, 5'd1};
    localparam x_set_t s_x      = {4'd5, 4'd6, 4'd4, 4'd5};
    localparam y_set_t s_y      = {5'd0, 5'd0, 5'd1, 5'd1};
    localparam x_set_t z_x      = {4'd4, 4'd5, 4'd5, 4'd6};
    localparam y_set_t z_y      = {5'd0, 5'd0, 5'd1, 5'd1};
    localparam x_set_t j_x      = {4'd6, 4'd4, 4'd5, 4'd6};
    localparam y_set_t j_y      = {5'd0, 5'd1, 5'd1, 5'd1};
    localparam x_set_t l_x      = {4'd3, 4'd3, 4'd4, 4'd5};
    localparam y_set_t l_y      = {5'd0, 5'd1, 5'd1, 5'd1};

    x_set_t xs;
    y_set_t ys;

    always_comb begin
        case (block_type)
            line:    xs = line_x;
            square:  xs = square_x;
            tee:     xs = tee_x;
            s_piece: xs = s_x;
            z_piece: xs = z_x;
            j_piece: xs = j_x;
            l_piece: xs = l_x;
            default: xs = '0;  // none
        endcase
        case (block_type)
            line:    ys = line_y;
            square:  ys = square_y;
            tee:     ys = tee_y;
            s_piece: ys = s_y;
            z_piece: ys = z_y;
            j_piece: ys = j_y;
            l_piece: ys = l_y;
            default: ys = '0;
        endcase
    end

    assign {spawn_x1, spawn_x2, spawn_x3, spawn_x4} = xs;
    assign {spawn_y1, spawn_y2, spawn_y3, spawn_y4} = ys;

endmodule

/* hw/move_pkg.sv */
package move_pkg;

    // raw code on the movement input with 110 and 111 unnamed
    typedef enum logic [2:0] {
        rot_cw  = 3'b000,
        rot_ccw = 3'b001,
        down    = 3'b010,
        left    = 3'b011,
        right   = 3'b100,
        idle    = 3'b101
    } movement_t;

    // one decoded action per clock
    typedef enum logic [2:0] {
        cmd_hold,
        cmd_spawn,
        cmd_down,
        cmd_left,
        cmd_right,
        cmd_rot_cw,
        cmd_rot_ccw
    } move_cmd_t;

endpackage

/* hw/piece_pkg.sv */
package piece_pkg;

    //////////////////////////////////////////////////////////////////////
    // playfield geometry
    //////////////////////////////////////////////////////////////////////

    localparam int grid_x_bits = 4;  // 16 columns
    localparam int grid_y_bits = 5;  // 32 rows

    typedef logic [grid_x_bits-1:0] coord_x_t;
    typedef logic [grid_y_bits-1:0] coord_y_t;

    //////////////////////////////////////////////////////////////////////
    // tetromino kinds
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        none    = 3'd0,  // empty piece
        line    = 3'd1,
        square  = 3'd2,
        tee     = 3'd3,  // inverted t
        s_piece = 3'd4,
        z_piece = 3'd5,
        j_piece = 3'd6,
        l_piece = 3'd7
    } block_kind_t;

endpackage
